// File: mem_sys_params.svh
// memory subsystem parameters
`ifndef MEM_SYS_PARAMS_SVH
`define MEM_SYS_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

// byte address width on every port
`define MS_ADDR_W 32
// scalar core data width
`define MS_NARROW_W 64
// vector unit and system bus data width
`define MS_WIDE_W 128
// master-side transaction id, system side adds one source bit
`define MS_ID_W 4

// cache-line size seen by the invalidation port
`define MS_LINE_BYTES 16
// core reads in flight through the upsizer
`define MS_MAX_RD 4

`endif

// File: bus_pkg.sv
// request and response bus types
`include "mem_sys_params.svh"

package bus_pkg;

  // core port, one 64-bit beat
  typedef struct packed {
    logic [`MS_ADDR_W-1:0]     addr;
    logic                      we;
    logic [`MS_NARROW_W-1:0]   data;
    logic [`MS_NARROW_W/8-1:0] strb;
    logic [`MS_ID_W-1:0]       id;
  } narrow_req_t;

  typedef struct packed {
    logic [`MS_NARROW_W-1:0] data;
    logic [`MS_ID_W-1:0]     id;
    // set on write acknowledge, clear on read data
    logic                    wack;
  } narrow_rsp_t;

  // vector port and upsizer output
  typedef struct packed {
    logic [`MS_ADDR_W-1:0]   addr;
    logic                    we;
    logic [`MS_WIDE_W-1:0]   data;
    logic [`MS_WIDE_W/8-1:0] strb;
    logic [`MS_ID_W-1:0]     id;
  } wide_req_t;

  typedef struct packed {
    logic [`MS_WIDE_W-1:0] data;
    logic [`MS_ID_W-1:0]   id;
    logic                  wack;
  } wide_rsp_t;

  // system side, id msb names the source master
  typedef struct packed {
    logic [`MS_ADDR_W-1:0]   addr;
    logic                    we;
    logic [`MS_WIDE_W-1:0]   data;
    logic [`MS_WIDE_W/8-1:0] strb;
    logic [`MS_ID_W:0]       id;
  } sys_req_t;

  typedef struct packed {
    logic [`MS_WIDE_W-1:0] data;
    logic [`MS_ID_W:0]     id;
    logic                  wack;
  } sys_rsp_t;

endpackage

// File: coh_pkg.sv
// coherence message types
`include "mem_sys_params.svh"

package coh_pkg;

  // byte offset bits inside one cache line
  localparam int unsigned LINE_OFF_W = $clog2(`MS_LINE_BYTES);

  // address with the line offset dropped
  typedef logic [`MS_ADDR_W-LINE_OFF_W-1:0] line_addr_t;

  // one invalidation request toward the core cache
  typedef struct packed {
    line_addr_t          line;
    // id of the vector write behind it
    logic [`MS_ID_W-1:0] id;
  } inval_t;

endpackage

// File: spill_reg.sv
// two-entry register slice
module spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // slot a takes new data, slot b holds the older entry on a stall
  logic     a_full_q;
  logic     b_full_q;
  payload_t a_data_q;
  payload_t b_data_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  assign a_fill  = valid_i && ready_o;
  // a empties whenever b is free, either to the output or into b
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // payload slots
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // both handshake outputs come from flops only
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  // b is older and leaves first
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  // a stalled output keeps its payload until taken
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

// File: narrow_upsizer.sv
// narrow to wide bus upsizer
`include "mem_sys_params.svh"

module narrow_upsizer (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // core side
  input  bus_pkg::narrow_req_t nreq_i,
  input  logic                 nreq_valid_i,
  output logic                 nreq_ready_o,
  output bus_pkg::narrow_rsp_t nrsp_o,
  output logic                 nrsp_valid_o,
  input  logic                 nrsp_ready_i,
  // wide side toward the arbiter
  output bus_pkg::wide_req_t   wreq_o,
  output logic                 wreq_valid_o,
  input  logic                 wreq_ready_i,
  input  bus_pkg::wide_rsp_t   wrsp_i,
  input  logic                 wrsp_valid_i,
  output logic                 wrsp_ready_o
);

  localparam int unsigned NW       = `MS_NARROW_W;
  localparam int unsigned NS       = `MS_NARROW_W / 8;
  localparam int unsigned HALF_BIT = $clog2(NS);
  localparam int unsigned DEPTH    = `MS_MAX_RD;
  localparam int unsigned PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // in-order queue of read halves
  logic [DEPTH-1:0] half_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   cnt_q;
  logic             rd_block;
  logic             push;
  logic             pop;

  //////////////////////////////////////////////////////////////////////
  // request direction
  //////////////////////////////////////////////////////////////////////

  // hold back reads once the queue is full
  assign rd_block     = !nreq_i.we && (cnt_q == (PTR_W + 1)'(DEPTH));
  assign wreq_valid_o = nreq_valid_i && !rd_block;
  assign nreq_ready_o = wreq_ready_i && !rd_block;

  always_comb begin
    wreq_o.addr = nreq_i.addr;
    wreq_o.we   = nreq_i.we;
    wreq_o.id   = nreq_i.id;
    // data lands in both halves, strobe picks the live one
    wreq_o.data = {2{nreq_i.data}};
    if (nreq_i.addr[HALF_BIT]) begin
      wreq_o.strb = {nreq_i.strb, {NS{1'b0}}};
    end else begin
      wreq_o.strb = {{NS{1'b0}}, nreq_i.strb};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response direction
  //////////////////////////////////////////////////////////////////////

  assign push = nreq_valid_i && nreq_ready_o && !nreq_i.we;
  // only read data pops, write acks carry no half
  assign pop  = wrsp_valid_i && wrsp_ready_o && !wrsp_i.wack;

  assign nrsp_valid_o = wrsp_valid_i;
  assign wrsp_ready_o = nrsp_ready_i;
  assign nrsp_o.id    = wrsp_i.id;
  assign nrsp_o.wack  = wrsp_i.wack;
  assign nrsp_o.data  = half_q[rd_ptr_q] ? wrsp_i.data[2*NW-1:NW] : wrsp_i.data[NW-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
    end
  end

  // queue storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      half_q[wr_ptr_q] <= nreq_i.addr[HALF_BIT];
    end
  end

endmodule

// File: inval_filter.sv
// vector write invalidation filter
`include "mem_sys_params.svh"

module inval_filter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               coh_en_i,
  // requests from the vector unit
  input  bus_pkg::wide_req_t sreq_i,
  input  logic               sreq_valid_i,
  output logic               sreq_ready_o,
  // requests toward the arbiter
  output bus_pkg::wide_req_t mreq_o,
  output logic               mreq_valid_o,
  input  logic               mreq_ready_i,
  // line invalidations toward the core cache
  output coh_pkg::inval_t    inval_o,
  output logic               inval_valid_o,
  input  logic               inval_ready_i
);

  logic                coh_wr;
  logic                pass;
  logic                inval_hs;
  logic                fwd_hs;
  // invalidation of the held write already taken
  logic                inval_done_q;
  coh_pkg::line_addr_t req_line;
  // line of the last accepted invalidation
  coh_pkg::line_addr_t inval_line_q;

  //////////////////////////////////////////////////////////////////////
  // gating
  //////////////////////////////////////////////////////////////////////

  assign coh_wr   = coh_en_i && sreq_i.we;
  assign req_line = sreq_i.addr[`MS_ADDR_W-1:coh_pkg::LINE_OFF_W];

  // reads and non-coherent writes go straight through
  assign pass = !coh_wr || inval_done_q;

  assign mreq_o       = sreq_i;
  assign mreq_valid_o = sreq_valid_i && pass;
  assign sreq_ready_o = mreq_ready_i && pass;

  // announce the line as soon as the write shows up
  assign inval_valid_o = sreq_valid_i && coh_wr && !inval_done_q;
  assign inval_o.line  = req_line;
  assign inval_o.id    = sreq_i.id;

  assign inval_hs = inval_valid_o && inval_ready_i;
  assign fwd_hs   = mreq_valid_o && mreq_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      inval_done_q <= 1'b0;
    end else if (fwd_hs) begin
      // cleared once the write leaves
      inval_done_q <= 1'b0;
    end else if (inval_hs) begin
      inval_done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (inval_hs) begin
      inval_line_q <= req_line;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // a coherent write leaves only after its own line was invalidated
  a_inval_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fwd_hs && coh_wr |-> inval_done_q && (inval_line_q == req_line));

endmodule

// File: bus_arbiter.sv
// round-robin system bus arbiter
`include "mem_sys_params.svh"

module bus_arbiter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // master 0, the upsized core path
  input  bus_pkg::wide_req_t m0_req_i,
  input  logic               m0_req_valid_i,
  output logic               m0_req_ready_o,
  output bus_pkg::wide_rsp_t m0_rsp_o,
  output logic               m0_rsp_valid_o,
  input  logic               m0_rsp_ready_i,
  // master 1, the filtered vector path
  input  bus_pkg::wide_req_t m1_req_i,
  input  logic               m1_req_valid_i,
  output logic               m1_req_ready_o,
  output bus_pkg::wide_rsp_t m1_rsp_o,
  output logic               m1_rsp_valid_o,
  input  logic               m1_rsp_ready_i,
  // system bus
  output bus_pkg::sys_req_t  sys_req_o,
  output logic               sys_req_valid_o,
  input  logic               sys_req_ready_i,
  input  bus_pkg::sys_rsp_t  sys_rsp_i,
  input  logic               sys_rsp_valid_i,
  output logic               sys_rsp_ready_o
);

  // outstanding counter width per master
  localparam int unsigned OUT_W = 8;

  logic                  sel;
  // last granted master
  logic                  rr_q;
  logic                  arb_valid;
  logic                  arb_ready;
  bus_pkg::wide_req_t    arb_src;
  bus_pkg::sys_req_t     arb_req;
  bus_pkg::sys_rsp_t     rsp_q;
  bus_pkg::wide_rsp_t    rsp_strip;
  logic                  rsp_valid;
  logic                  rsp_ready;
  logic                  rsp_src;
  logic [1:0]            req_hs;
  logic [1:0]            rsp_hs;
  logic [1:0][OUT_W-1:0] out_cnt_q;

  //////////////////////////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////////////////////////

  // m1 wins when alone or when m0 went last
  assign sel       = m1_req_valid_i && (!m0_req_valid_i || !rr_q);
  assign arb_valid = m0_req_valid_i || m1_req_valid_i;
  assign arb_src   = sel ? m1_req_i : m0_req_i;

  assign m0_req_ready_o = arb_ready && !sel;
  assign m1_req_ready_o = arb_ready && sel;

  always_comb begin
    arb_req.addr = arb_src.addr;
    arb_req.we   = arb_src.we;
    arb_req.data = arb_src.data;
    arb_req.strb = arb_src.strb;
    // source bit on top of the master id
    arb_req.id   = {sel, arb_src.id};
  end

  assign req_hs = {m1_req_valid_i && m1_req_ready_o, m0_req_valid_i && m0_req_ready_o};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= 1'b1;
    end else if (arb_valid && arb_ready) begin
      rr_q <= sel;
    end
  end

  spill_reg #(
    .payload_t (bus_pkg::sys_req_t)
  ) u_req_spill (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (arb_valid),
    .ready_o (arb_ready),
    .data_i  (arb_req),
    .valid_o (sys_req_valid_o),
    .ready_i (sys_req_ready_i),
    .data_o  (sys_req_o)
  );

  //////////////////////////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////////////////////////

  spill_reg #(
    .payload_t (bus_pkg::sys_rsp_t)
  ) u_rsp_spill (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (sys_rsp_valid_i),
    .ready_o (sys_rsp_ready_o),
    .data_i  (sys_rsp_i),
    .valid_o (rsp_valid),
    .ready_i (rsp_ready),
    .data_o  (rsp_q)
  );

  // steer by the source bit, then drop it
  assign rsp_src        = rsp_q.id[`MS_ID_W];
  assign rsp_strip.data = rsp_q.data;
  assign rsp_strip.id   = rsp_q.id[`MS_ID_W-1:0];
  assign rsp_strip.wack = rsp_q.wack;

  assign m0_rsp_o       = rsp_strip;
  assign m1_rsp_o       = rsp_strip;
  assign m0_rsp_valid_o = rsp_valid && !rsp_src;
  assign m1_rsp_valid_o = rsp_valid && rsp_src;
  assign rsp_ready      = rsp_src ? m1_rsp_ready_i : m0_rsp_ready_i;

  //////////////////////////////////////////////////////////////////////
  // outstanding bookkeeping
  //////////////////////////////////////////////////////////////////////

  assign rsp_hs[0] = sys_rsp_valid_i && sys_rsp_ready_o && !sys_rsp_i.id[`MS_ID_W];
  assign rsp_hs[1] = sys_rsp_valid_i && sys_rsp_ready_o && sys_rsp_i.id[`MS_ID_W];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_cnt_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        out_cnt_q[i] <= out_cnt_q[i] + OUT_W'(req_hs[i]) - OUT_W'(rsp_hs[i]);
      end
    end
  end

  // system responses only for masters still waiting
  a_rsp_src_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sys_rsp_valid_i && sys_rsp_ready_o |-> out_cnt_q[sys_rsp_i.id[`MS_ID_W]] != '0);

endmodule

// File: mem_system_top.sv
// memory subsystem top level
module mem_system_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 coh_en_i,
  // scalar core
  input  bus_pkg::narrow_req_t core_req_i,
  input  logic                 core_req_valid_i,
  output logic                 core_req_ready_o,
  output bus_pkg::narrow_rsp_t core_rsp_o,
  output logic                 core_rsp_valid_o,
  input  logic                 core_rsp_ready_i,
  // vector unit
  input  bus_pkg::wide_req_t   vec_req_i,
  input  logic                 vec_req_valid_i,
  output logic                 vec_req_ready_o,
  output bus_pkg::wide_rsp_t   vec_rsp_o,
  output logic                 vec_rsp_valid_o,
  input  logic                 vec_rsp_ready_i,
  // system bus
  output bus_pkg::sys_req_t    sys_req_o,
  output logic                 sys_req_valid_o,
  input  logic                 sys_req_ready_i,
  input  bus_pkg::sys_rsp_t    sys_rsp_i,
  input  logic                 sys_rsp_valid_i,
  output logic                 sys_rsp_ready_o,
  // line invalidations
  output coh_pkg::inval_t      inval_o,
  output logic                 inval_valid_o,
  input  logic                 inval_ready_i
);

  // upsized core path, arbiter port 0
  bus_pkg::wide_req_t up_req;
  logic               up_req_valid;
  logic               up_req_ready;
  bus_pkg::wide_rsp_t up_rsp;
  logic               up_rsp_valid;
  logic               up_rsp_ready;
  // filtered vector path, arbiter port 1
  bus_pkg::wide_req_t flt_req;
  logic               flt_req_valid;
  logic               flt_req_ready;

  narrow_upsizer u_narrow_upsizer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .nreq_i       (core_req_i),
    .nreq_valid_i (core_req_valid_i),
    .nreq_ready_o (core_req_ready_o),
    .nrsp_o       (core_rsp_o),
    .nrsp_valid_o (core_rsp_valid_o),
    .nrsp_ready_i (core_rsp_ready_i),
    .wreq_o       (up_req),
    .wreq_valid_o (up_req_valid),
    .wreq_ready_i (up_req_ready),
    .wrsp_i       (up_rsp),
    .wrsp_valid_i (up_rsp_valid),
    .wrsp_ready_o (up_rsp_ready)
  );

  inval_filter u_inval_filter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .coh_en_i      (coh_en_i),
    .sreq_i        (vec_req_i),
    .sreq_valid_i  (vec_req_valid_i),
    .sreq_ready_o  (vec_req_ready_o),
    .mreq_o        (flt_req),
    .mreq_valid_o  (flt_req_valid),
    .mreq_ready_i  (flt_req_ready),
    .inval_o       (inval_o),
    .inval_valid_o (inval_valid_o),
    .inval_ready_i (inval_ready_i)
  );

  // vector responses go back untouched
  bus_arbiter u_bus_arbiter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .m0_req_i        (up_req),
    .m0_req_valid_i  (up_req_valid),
    .m0_req_ready_o  (up_req_ready),
    .m0_rsp_o        (up_rsp),
    .m0_rsp_valid_o  (up_rsp_valid),
    .m0_rsp_ready_i  (up_rsp_ready),
    .m1_req_i        (flt_req),
    .m1_req_valid_i  (flt_req_valid),
    .m1_req_ready_o  (flt_req_ready),
    .m1_rsp_o        (vec_rsp_o),
    .m1_rsp_valid_o  (vec_rsp_valid_o),
    .m1_rsp_ready_i  (vec_rsp_ready_i),
    .sys_req_o       (sys_req_o),
    .sys_req_valid_o (sys_req_valid_o),
    .sys_req_ready_i (sys_req_ready_i),
    .sys_rsp_i       (sys_rsp_i),
    .sys_rsp_valid_i (sys_rsp_valid_i),
    .sys_rsp_ready_o (sys_rsp_ready_o)
  );

endmodule

// File: tb_mem_system.sv
// memory subsystem testbench
`include "mem_sys_params.svh"

module tb_mem_system;
  timeunit 1ns;
  timeprecision 1ps;

  // core, phase two and phase three traffic
  localparam int N_TXN   = 40 + 2 * 60 + 2 * 60;
  localparam int TIMEOUT = 200 * N_TXN + 1000;
  localparam logic [`MS_ID_W-1:0] CORE_ID = 4'h5;

  logic clk_i;
  logic rst_n_i;
  logic coh_en_i;
  bus_pkg::narrow_req_t core_req_i;
  logic core_req_valid_i;
  logic core_req_ready_o;
  bus_pkg::narrow_rsp_t core_rsp_o;
  logic core_rsp_valid_o;
  logic core_rsp_ready_i;
  bus_pkg::wide_req_t vec_req_i;
  logic vec_req_valid_i;
  logic vec_req_ready_o;
  bus_pkg::wide_rsp_t vec_rsp_o;
  logic vec_rsp_valid_o;
  logic vec_rsp_ready_i;
  bus_pkg::sys_req_t sys_req_o;
  logic sys_req_valid_o;
  logic sys_req_ready_i;
  bus_pkg::sys_rsp_t sys_rsp_i;
  logic sys_rsp_valid_i;
  logic sys_rsp_ready_o;
  coh_pkg::inval_t inval_o;
  logic inval_valid_o;
  logic inval_ready_i;

  integer seed = 49;
  int cycles = 0;
  int err_value = 0;
  int err_fault = 0;
  // scoreboard state
  logic [7:0] sysmem [logic [31:0]];
  logic [7:0] refmem [logic [31:0]];
  bus_pkg::sys_req_t exp_q[$];
  bus_pkg::sys_rsp_t mem_rsp_q[$];
  bus_pkg::narrow_rsp_t core_exp[$];
  bus_pkg::wide_rsp_t vec_exp[$];
  int core_rd_out = 0;
  logic inval_done = 1'b0;
  logic rsp_taken = 1'b0;
  logic last_src = 1'b0;
  logic have_last = 1'b0;
  int n_inval = 0;
  int n_coh_wr = 0;

  mem_system_top u_mem_system_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic flag_mismatch(input string msg);
    err_value++;
    $display("[ERROR] %0d ns: %s", $time, msg);
  endtask

  task automatic flag_fault(input string msg);
    err_fault++;
    $display("check failed at %0d ns: %s", $time, msg);
  endtask

  task automatic finish_run(input bit timed_out);
    $display("error counts: %0d wrong values, %0d other failures", err_value, err_fault);
    if (!timed_out && err_value == 0 && err_fault == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // untouched bytes read back a pattern of their full address
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] sys_byte(input logic [31:0] a);
    if (sysmem.exists(a)) begin
      return sysmem[a];
    end
    return fill_byte(a);
  endfunction

  function automatic logic [7:0] ref_byte(input logic [31:0] a);
    if (refmem.exists(a)) begin
      return refmem[a];
    end
    return fill_byte(a);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // master drivers
  //////////////////////////////////////////////////////////////////////

  // core stays below 0x200 and vector lives at 0x1000
  task automatic core_run(input int n);
    bus_pkg::narrow_req_t r;
    int i;
    for (i = 0; i < n; i++) begin
      r.addr = {23'h0, 6'($random(seed)), 3'b000};
      r.we   = 1'($random(seed));
      r.data = {$random(seed), $random(seed)};
      r.strb = 8'($random(seed));
      r.id   = CORE_ID;
      core_req_i       = r;
      core_req_valid_i = 1'b1;
      do @(posedge clk_i); while (!core_req_ready_o);
      @(negedge clk_i);
      core_req_valid_i = 1'b0;
      // occasional idle gap
      if (($random(seed) & 3) == 0) begin
        repeat (1 + ($random(seed) & 3)) @(negedge clk_i);
      end
    end
  endtask

  task automatic vec_run(input int n);
    bus_pkg::wide_req_t r;
    int i;
    for (i = 0; i < n; i++) begin
      r.addr = {20'h00001, 3'b000, 5'($random(seed)), 4'h0};
      r.we   = 1'($random(seed));
      r.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
      r.strb = 16'($random(seed));
      r.id   = 4'($random(seed));
      vec_req_i       = r;
      vec_req_valid_i = 1'b1;
      do @(posedge clk_i); while (!vec_req_ready_o);
      @(negedge clk_i);
      vec_req_valid_i = 1'b0;
      if (($random(seed) & 3) == 0) begin
        repeat (1 + ($random(seed) & 3)) @(negedge clk_i);
      end
    end
  endtask

  task automatic run_phase(input logic coh, input int n_core, input int n_vec);
    @(negedge clk_i);
    coh_en_i = coh;
    fork
      core_run(n_core);
      vec_run(n_vec);
    join
  endtask

  //////////////////////////////////////////////////////////////////////
  // system memory responder and ready stalls
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : responder
    if (rst_n_i) begin
      sys_req_ready_i  = ($random(seed) & 3) != 0;
      inval_ready_i    = ($random(seed) & 1) != 0;
      core_rsp_ready_i = ($random(seed) & 7) != 0;
      vec_rsp_ready_i  = ($random(seed) & 7) != 0;
      if (rsp_taken) begin
        sys_rsp_valid_i = 1'b0;
      end
      rsp_taken = 1'b0;
      // next answer after a random delay, in acceptance order
      if (!sys_rsp_valid_i && mem_rsp_q.size() != 0 && ($random(seed) & 3) == 0) begin
        sys_rsp_i       = mem_rsp_q.pop_front();
        sys_rsp_valid_i = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // monitors and scoreboard
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : monitor
    bus_pkg::sys_req_t exp_s;
    bus_pkg::sys_rsp_t mrsp;
    bus_pkg::narrow_rsp_t exp_n;
    bus_pkg::wide_rsp_t exp_w;
    logic [31:0] base;
    logic core_eff;
    logic vec_eff;
    logic src;
    int b;
    if (rst_n_i) begin
      // requests the arbiter can actually see
      core_eff = core_req_valid_i && (core_req_i.we || core_rd_out < `MS_MAX_RD);
      vec_eff  = vec_req_valid_i && (!(coh_en_i && vec_req_i.we) || inval_done);
      src      = vec_req_valid_i && vec_req_ready_o;
      if (core_req_valid_i && core_req_ready_o) begin
        exp_s.addr = core_req_i.addr;
        exp_s.we   = core_req_i.we;
        exp_s.data = {2{core_req_i.data}};
        exp_s.strb = core_req_i.addr[3] ? {core_req_i.strb, 8'h00} : {8'h00, core_req_i.strb};
        exp_s.id   = {1'b0, core_req_i.id};
        exp_q.push_back(exp_s);
        base = {core_req_i.addr[31:3], 3'b000};
        exp_n.id   = core_req_i.id;
        exp_n.wack = core_req_i.we;
        for (b = 0; b < 8; b++) begin
          if (core_req_i.we && core_req_i.strb[b]) begin
            refmem[base + b] = core_req_i.data[8*b +: 8];
          end
          exp_n.data[8*b +: 8] = ref_byte(base + b);
        end
        core_exp.push_back(exp_n);
        if (!core_req_i.we) begin
          core_rd_out++;
        end
      end
      if (src) begin
        exp_s.addr = vec_req_i.addr;
        exp_s.we   = vec_req_i.we;
        exp_s.data = vec_req_i.data;
        exp_s.strb = vec_req_i.strb;
        exp_s.id   = {1'b1, vec_req_i.id};
        exp_q.push_back(exp_s);
        base = {vec_req_i.addr[31:4], 4'h0};
        exp_w.id   = vec_req_i.id;
        exp_w.wack = vec_req_i.we;
        for (b = 0; b < 16; b++) begin
          if (vec_req_i.we && vec_req_i.strb[b]) begin
            refmem[base + b] = vec_req_i.data[8*b +: 8];
          end
          exp_w.data[8*b +: 8] = ref_byte(base + b);
        end
        vec_exp.push_back(exp_w);
        if (coh_en_i && vec_req_i.we) begin
          if (!inval_done) begin
            flag_fault("coherent vector write forwarded before its invalidation");
          end
          inval_done = 1'b0;
          n_coh_wr++;
        end
      end
      // contested round-robin grants must alternate
      if ((core_req_valid_i && core_req_ready_o) || src) begin
        if (core_eff && vec_eff && have_last && src == last_src) begin
          flag_mismatch($sformatf("master %0d granted twice while both waited", src));
        end
        last_src  = src;
        have_last = 1'b1;
      end

      // invalidation port
      if (inval_valid_o && inval_ready_i) begin
        n_inval++;
        if (!(vec_req_valid_i && vec_req_i.we && coh_en_i)) begin
          flag_fault("invalidation without a coherent vector write");
        end else if (inval_done) begin
          flag_fault("second invalidation for one vector write");
        end else if (inval_o.line !== coh_pkg::line_addr_t'(vec_req_i.addr / `MS_LINE_BYTES) ||
                     inval_o.id !== vec_req_i.id) begin
          flag_mismatch($sformatf("invalidation line %h id %h for addr %h id %h",
                                  inval_o.line, inval_o.id, vec_req_i.addr, vec_req_i.id));
        end
        inval_done = 1'b1;
      end

      // system bus and memory model
      if (sys_req_valid_o && sys_req_ready_i) begin
        if (exp_q.size() == 0) begin
          flag_fault("system request with nothing pending");
        end else begin
          exp_s = exp_q.pop_front();
          if (sys_req_o !== exp_s) begin
            flag_mismatch($sformatf("system request addr %h id %h, expected addr %h id %h",
                                    sys_req_o.addr, sys_req_o.id, exp_s.addr, exp_s.id));
          end
        end
        base = {sys_req_o.addr[31:4], 4'h0};
        mrsp.id   = sys_req_o.id;
        mrsp.wack = sys_req_o.we;
        mrsp.data = '0;
        for (b = 0; b < 16; b++) begin
          if (sys_req_o.we && sys_req_o.strb[b]) begin
            sysmem[base + b] = sys_req_o.data[8*b +: 8];
          end else if (!sys_req_o.we) begin
            mrsp.data[8*b +: 8] = sys_byte(base + b);
          end
        end
        mem_rsp_q.push_back(mrsp);
      end
      if (sys_rsp_valid_i && sys_rsp_ready_o) begin
        rsp_taken = 1'b1;
      end

      // responses back at the masters
      if (core_rsp_valid_o && core_rsp_ready_i) begin
        if (core_exp.size() == 0) begin
          flag_fault("core response with nothing pending");
        end else begin
          exp_n = core_exp.pop_front();
          if (core_rsp_o.id !== exp_n.id || core_rsp_o.wack !== exp_n.wack ||
              (!exp_n.wack && core_rsp_o.data !== exp_n.data)) begin
            flag_mismatch($sformatf("core response id %h data %h, expected id %h data %h",
                                    core_rsp_o.id, core_rsp_o.data, exp_n.id, exp_n.data));
          end
        end
        if (!core_rsp_o.wack) begin
          core_rd_out--;
        end
      end
      if (vec_rsp_valid_o && vec_rsp_ready_i) begin
        if (vec_exp.size() == 0) begin
          flag_fault("vector response with nothing pending");
        end else begin
          exp_w = vec_exp.pop_front();
          if (vec_rsp_o.id !== exp_w.id || vec_rsp_o.wack !== exp_w.wack ||
              (!exp_w.wack && vec_rsp_o.data !== exp_w.data)) begin
            flag_mismatch($sformatf("vector response id %h data %h, expected id %h data %h",
                                    vec_rsp_o.id, vec_rsp_o.data, exp_w.id, exp_w.data));
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    if (rst_n_i) begin
      cycles++;
    end
    if (cycles > TIMEOUT) begin
      flag_fault($sformatf("run did not finish within %0d cycles", TIMEOUT));
      finish_run(1'b1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n_i          = 1'b0;
    coh_en_i         = 1'b0;
    core_req_i       = '0;
    core_req_valid_i = 1'b0;
    core_rsp_ready_i = 1'b0;
    vec_req_i        = '0;
    vec_req_valid_i  = 1'b0;
    vec_rsp_ready_i  = 1'b0;
    sys_req_ready_i  = 1'b0;
    sys_rsp_i        = '0;
    sys_rsp_valid_i  = 1'b0;
    inval_ready_i    = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    // idle outputs right after reset
    repeat (10) begin
      @(posedge clk_i);
      if (sys_req_valid_o || core_rsp_valid_o || vec_rsp_valid_o || inval_valid_o) begin
        flag_mismatch("valid output high after reset without stimulus");
      end
    end
    run_phase(1'b0, 40, 0);
    run_phase(1'b1, 60, 60);
    run_phase(1'b0, 60, 60);
    // let every response drain
    while (exp_q.size() != 0 || core_exp.size() != 0 || vec_exp.size() != 0 ||
           mem_rsp_q.size() != 0 || sys_rsp_valid_i) begin
      @(posedge clk_i);
    end
    repeat (5) @(posedge clk_i);
    if (n_inval != n_coh_wr) begin
      flag_fault($sformatf("%0d invalidations for %0d coherent writes", n_inval, n_coh_wr));
    end
    finish_run(1'b0);
  end

endmodule

// File: compile.f
+incdir+.
bus_pkg.sv
coh_pkg.sv
spill_reg.sv
narrow_upsizer.sv
inval_filter.sv
bus_arbiter.sv
mem_system_top.sv
tb_mem_system.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_mem_system -f compile.f -o tb_mem_system

./obj_dir/tb_mem_system | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
